// File: include/cam_config.svh
`ifndef CAM_CONFIG_SVH
`define CAM_CONFIG_SVH

// sensor bus address, 8-bit write form
`define CAM_I2C_ADDR    8'h6c

// chip id check
`define CAM_ID_REG      16'h300b
`define CAM_ID_VALUE    8'h88

// table entries whose device byte is this tag are pauses
`define CAM_DELAY_TAG   8'haa
`define CAM_DELAY_UNIT  16'd40      // clocks per delay count

// register table layout
`define CAM_TABLE_LEN   8'd22
`define CAM_LIVE_START  8'd13       // first entry of the refresh loop

// idle time between failed id reads
`define CAM_RETRY_GAP   16'd64

`endif

// File: src/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

   typedef enum logic {
      OP_WRITE_REG,           // addr, reg hi, reg lo, data
      OP_READ_REG             // pointer write, then one byte read
   } i2c_op_e;

   typedef struct packed {
      i2c_op_e     op;
      logic [7:0]  dev_addr;  // write form, bit 0 clear
      logic [15:0] reg_addr;
      logic [7:0]  wdata;
   } i2c_cmd_t;

   typedef struct packed {
      logic        done;      // single cycle
      logic        nack;
      logic [7:0]  rdata;
   } i2c_rsp_t;

   typedef enum logic [2:0] {
      I2C_IDLE,
      I2C_START,
      I2C_TX,
      I2C_ACK,
      I2C_RX,
      I2C_MNACK,
      I2C_STOP,
      I2C_GAP                 // idle bit before the repeated start
   } i2c_state_e;

endpackage

`default_nettype wire

// File: src/cam_pkg.sv
`default_nettype none

package cam_pkg;

   typedef struct packed {
      logic [7:0]  tag;       // device address or delay tag
      logic [15:0] reg_addr;
      logic [7:0]  value;     // delay count on delay entries
   } cam_entry_t;

   // settings rewritten in the refresh loop
   typedef struct packed {
      logic [23:0] exposure;
      logic [7:0]  test_pattern;
      logic [15:0] width;
      logic [15:0] height;
   } cam_live_t;

   typedef enum logic [2:0] {
      SEQ_START,              // issue id read
      SEQ_ID_WAIT,
      SEQ_RETRY,
      SEQ_FETCH,              // decode table entry
      SEQ_WRITE,
      SEQ_DELAY,
      SEQ_NEXT
   } seq_state_e;

endpackage

`default_nettype wire

// File: src/i2c_master.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_master (
   input  logic              CLK_400K,
   input  logic              RESET_N,
   input  logic              cmd_valid,
   input  i2c_pkg::i2c_cmd_t cmd,
   input  logic              sda_in,
   output i2c_pkg::i2c_rsp_t rsp,
   output logic              scl,
   output logic              sda_drive_low
);
   import i2c_pkg::*;

   i2c_state_e state;
   logic [1:0] phase;        // scl high in phases 1 and 2
   logic [7:0] shift;        // tx byte, or rx byte on reads
   logic [2:0] bit_cnt;
   logic [1:0] byte_cnt;     // byte just sent in the pointer part
   logic       rd_again;     // past the repeated start
   logic       nack_q;
   logic       done_q;
   logic       is_read;
   logic [1:0] last_byte;

   assign is_read   = (cmd.op == OP_READ_REG);
   assign last_byte = is_read ? 2'd2 : 2'd3;   // reads stop after the pointer

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state    <= I2C_IDLE;
         phase    <= 2'd0;
         bit_cnt  <= 3'd0;
         byte_cnt <= 2'd0;
         rd_again <= 1'b0;
         nack_q   <= 1'b0;
         done_q   <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (state != I2C_IDLE)
            phase <= phase + 2'd1;
         case (state)
            I2C_IDLE: begin
               if (cmd_valid && !done_q) begin   // valid still high in the done cycle
                  state    <= I2C_START;
                  byte_cnt <= 2'd0;
                  rd_again <= 1'b0;
                  nack_q   <= 1'b0;
               end
            end
            I2C_START: begin
               if (phase == 2'd3)
                  state <= I2C_TX;
            end
            I2C_TX: begin
               if (phase == 2'd3) begin
                  bit_cnt <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7)
                     state <= I2C_ACK;
               end
            end
            I2C_ACK: begin
               if (phase == 2'd1 && sda_in)
                  nack_q <= 1'b1;                 // keep going, report at done
               if (phase == 2'd3) begin
                  byte_cnt <= byte_cnt + 2'd1;
                  if (rd_again)
                     state <= I2C_RX;
                  else if (byte_cnt == last_byte)
                     state <= I2C_STOP;
                  else
                     state <= I2C_TX;
               end
            end
            I2C_RX: begin
               if (phase == 2'd3) begin
                  bit_cnt <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7)
                     state <= I2C_MNACK;
               end
            end
            I2C_MNACK: begin
               if (phase == 2'd3)
                  state <= I2C_STOP;
            end
            I2C_STOP: begin
               if (phase == 2'd3) begin
                  if (is_read && !rd_again) begin
                     state    <= I2C_GAP;
                     rd_again <= 1'b1;
                  end else begin
                     state  <= I2C_IDLE;
                     done_q <= 1'b1;
                  end
               end
            end
            I2C_GAP: begin
               if (phase == 2'd3)
                  state <= I2C_START;
            end
            default: state <= I2C_IDLE;
         endcase
      end
   end

   // byte shifter, msb first on the wire
   always_ff @(posedge CLK_400K) begin
      if (state == I2C_START && phase == 2'd3)
         shift <= rd_again ? {cmd.dev_addr[7:1], 1'b1} : cmd.dev_addr;
      else if (state == I2C_TX && phase == 2'd3)
         shift <= {shift[6:0], 1'b0};
      else if (state == I2C_RX && phase == 2'd1)
         shift <= {shift[6:0], sda_in};     // mid scl high
      else if (state == I2C_ACK && phase == 2'd3) begin
         case (byte_cnt)
            2'd0:    shift <= cmd.reg_addr[15:8];
            2'd1:    shift <= cmd.reg_addr[7:0];
            default: shift <= cmd.wdata;
         endcase
      end
   end

   // sda moves only on the 3->0 phase edge, scl low on both sides
   always_comb begin
      scl           = 1'b1;
      sda_drive_low = 1'b0;
      case (state)
         I2C_START: begin
            scl           = (phase != 2'd3);
            sda_drive_low = phase[1];         // falls with scl high
         end
         I2C_TX: begin
            scl           = phase[0] ^ phase[1];
            sda_drive_low = ~shift[7];
         end
         I2C_ACK, I2C_RX, I2C_MNACK: begin
            scl = phase[0] ^ phase[1];        // line released
         end
         I2C_STOP: begin
            scl           = (phase != 2'd0);
            sda_drive_low = ~phase[1];        // rises with scl high
         end
         default: ;
      endcase
   end

   assign rsp = '{done: done_q, nack: nack_q, rdata: shift};

endmodule

`default_nettype wire

// File: src/cam_reg_table.sv
`timescale 1ns/100ps
`default_nettype none

`include "cam_config.svh"

module cam_reg_table (
   input  logic [7:0]         index,
   input  cam_pkg::cam_live_t live,
   output cam_pkg::cam_entry_t entry
);
   import cam_pkg::*;

   function automatic cam_entry_t wr(input logic [15:0] addr, input logic [7:0] val);
      cam_entry_t e;
      e = '{tag: `CAM_I2C_ADDR, reg_addr: addr, value: val};
      return e;
   endfunction

   function automatic cam_entry_t dly(input logic [7:0] units);
      cam_entry_t e;
      e = '{tag: `CAM_DELAY_TAG, reg_addr: 16'h0000, value: units};
      return e;
   endfunction

   always_comb begin
      case (index)
         8'd0:  entry = wr(16'h0103, 8'h01);      // software reset
         8'd1:  entry = dly(8'd10);
         8'd2:  entry = wr(16'h0100, 8'h00);      // standby
         8'd3:  entry = wr(16'h0302, 8'h18);      // pll1 multiplier
         8'd4:  entry = wr(16'h0303, 8'h00);
         8'd5:  entry = wr(16'h0304, 8'h03);      // mipi divider
         8'd6:  entry = wr(16'h3018, 8'h72);      // 4 lanes
         8'd7:  entry = wr(16'h3031, 8'h0a);      // 10-bit
         8'd8:  entry = wr(16'h380c, 8'h12);      // hts
         8'd9:  entry = wr(16'h380d, 8'h00);
         8'd10: entry = wr(16'h5000, 8'h16);      // isp blocks
         8'd11: entry = dly(8'd10);
         8'd12: entry = wr(16'h0100, 8'h01);      // streaming
         // refresh loop starts here
         8'd13: entry = wr(16'h3500, live.exposure[23:16]);
         8'd14: entry = wr(16'h3501, live.exposure[15:8]);
         8'd15: entry = wr(16'h3502, live.exposure[7:0]);
         8'd16: entry = wr(16'h5e00, live.test_pattern);
         8'd17: entry = wr(16'h3808, live.width[15:8]);
         8'd18: entry = wr(16'h3809, live.width[7:0]);
         8'd19: entry = wr(16'h380a, live.height[15:8]);
         8'd20: entry = wr(16'h380b, live.height[7:0]);
         8'd21: entry = dly(8'd10);
         default: entry = dly(8'd0);           // past the end, no-op
      endcase
   end

endmodule

`default_nettype wire

// File: src/cam_init_seq.sv
`timescale 1ns/100ps
`default_nettype none

`include "cam_config.svh"

module cam_init_seq (
   input  logic                CLK_400K,
   input  logic                RESET_N,
   input  cam_pkg::cam_entry_t entry,
   input  i2c_pkg::i2c_rsp_t   rsp,
   output logic [7:0]          index,
   output logic                cmd_valid,
   output i2c_pkg::i2c_cmd_t   cmd,
   output logic [7:0]          sensor_id,
   output logic                config_done
);
   import i2c_pkg::*;
   import cam_pkg::*;

   seq_state_e  state;
   logic [15:0] cnt;            // retry gap and delay counter
   logic [15:0] delay_cycles;
   logic        id_ok;
   logic        last_entry;
   logic        is_delay;

   assign delay_cycles = {8'd0, entry.value} * `CAM_DELAY_UNIT;
   assign id_ok        = !rsp.nack && (rsp.rdata == `CAM_ID_VALUE);
   assign last_entry   = (index == `CAM_TABLE_LEN - 8'd1);
   assign is_delay     = (entry.tag == `CAM_DELAY_TAG);

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state       <= SEQ_START;
         index       <= 8'd0;
         cmd_valid   <= 1'b0;
         cnt         <= 16'd0;
         sensor_id   <= 8'd0;
         config_done <= 1'b0;
      end else begin
         case (state)
            SEQ_START: begin
               cmd_valid <= 1'b1;
               state     <= SEQ_ID_WAIT;
            end
            SEQ_ID_WAIT: begin
               if (rsp.done) begin
                  cmd_valid <= 1'b0;
                  cnt       <= 16'd0;
                  if (id_ok) begin
                     sensor_id <= rsp.rdata;
                     index     <= 8'd0;     // walk always starts at the top
                     state     <= SEQ_FETCH;
                  end else begin
                     state <= SEQ_RETRY;
                  end
               end
            end
            SEQ_RETRY: begin
               if (cnt == `CAM_RETRY_GAP - 16'd1)
                  state <= SEQ_START;
               else
                  cnt <= cnt + 16'd1;
            end
            SEQ_FETCH: begin
               if (is_delay) begin
                  cnt   <= 16'd0;
                  state <= SEQ_DELAY;
               end else begin
                  cmd_valid <= 1'b1;
                  state     <= SEQ_WRITE;
               end
            end
            SEQ_WRITE: begin
               if (rsp.done) begin
                  cmd_valid <= 1'b0;
                  state     <= rsp.nack ? SEQ_START : SEQ_NEXT;   // lost sensor, redo id
               end
            end
            SEQ_DELAY: begin
               if (cnt == delay_cycles)
                  state <= SEQ_NEXT;
               else
                  cnt <= cnt + 16'd1;
            end
            SEQ_NEXT: begin
               state <= SEQ_FETCH;
               if (last_entry) begin
                  index       <= `CAM_LIVE_START;
                  config_done <= 1'b1;
               end else begin
                  index <= index + 8'd1;
               end
            end
            default: state <= SEQ_START;
         endcase
      end
   end

   // command payload, only looked at while cmd_valid is high
   always_ff @(posedge CLK_400K) begin
      if (state == SEQ_START)
         cmd <= '{op: OP_READ_REG, dev_addr: `CAM_I2C_ADDR,
                  reg_addr: `CAM_ID_REG, wdata: 8'h00};
      else if (state == SEQ_FETCH)
         cmd <= '{op: OP_WRITE_REG, dev_addr: entry.tag,
                  reg_addr: entry.reg_addr, wdata: entry.value};
   end

endmodule

`default_nettype wire

// File: src/cam_config_top.sv
`timescale 1ns/100ps
`default_nettype none

module cam_config_top (
   input  logic               CLK_400K,
   input  logic               RESET_N,
   input  cam_pkg::cam_live_t live,
   input  logic               sda_in,
   output logic               scl,
   output logic               sda_drive_low,
   output logic [7:0]         sensor_id,
   output logic               config_done
);
   import i2c_pkg::*;
   import cam_pkg::*;

   cam_entry_t entry;
   logic [7:0] index;
   logic       cmd_valid;
   i2c_cmd_t   cmd;
   i2c_rsp_t   rsp;

   cam_init_seq u_seq (
      .CLK_400K    (CLK_400K),
      .RESET_N     (RESET_N),
      .entry       (entry),
      .rsp         (rsp),
      .index       (index),
      .cmd_valid   (cmd_valid),
      .cmd         (cmd),
      .sensor_id   (sensor_id),
      .config_done (config_done)
   );

   cam_reg_table u_table (
      .index (index),
      .live  (live),
      .entry (entry)
   );

   i2c_master u_i2c (
      .CLK_400K      (CLK_400K),
      .RESET_N       (RESET_N),
      .cmd_valid     (cmd_valid),
      .cmd           (cmd),
      .sda_in        (sda_in),
      .rsp           (rsp),
      .scl           (scl),
      .sda_drive_low (sda_drive_low)
   );

endmodule

`default_nettype wire

// File: verif/i2c_sensor_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "cam_config.svh"

module i2c_sensor_model (
   input  logic                CLK_400K,
   input  logic                RESET_N,
   input  logic                scl,
   input  logic                sda,
   input  logic                refuse,      // nack the next address byte
   output logic                sda_pull,
   output logic                start_seen,
   output logic                stop_seen,
   output logic                wr_valid,
   output cam_pkg::cam_entry_t wr_rep,
   output logic                rd_valid,
   output logic [15:0]         rd_reg,
   output logic                refused
);
   import cam_pkg::*;

   logic        scl_q = 1'b1;
   logic        sda_q = 1'b1;
   logic        active = 1'b0;
   logic        pull = 1'b0;
   logic        go_read = 1'b0;
   logic        reading = 1'b0;
   logic [3:0]  bit_cnt = 4'd0;    // bits seen in the current byte, ack is bit 9
   logic [1:0]  byte_cnt = 2'd0;
   logic [7:0]  shift = 8'h00;
   logic [7:0]  dev = 8'h00;
   logic [7:0]  rdata = 8'h00;
   logic [15:0] ptr = 16'h0000;
   int          reads = 0;
   logic        start_p = 1'b0;
   logic        stop_p = 1'b0;
   logic        wr_p = 1'b0;
   logic        rd_p = 1'b0;
   logic        ref_p = 1'b0;
   cam_entry_t  rep = '0;

   assign sda_pull   = pull;
   assign start_seen = start_p;
   assign stop_seen  = stop_p;
   assign wr_valid   = wr_p;
   assign wr_rep     = rep;
   assign rd_valid   = rd_p;
   assign rd_reg     = ptr;
   assign refused    = ref_p;

   always @(posedge CLK_400K) begin
      #2;                             // after the testbench drives
      start_p = 1'b0;
      stop_p  = 1'b0;
      wr_p    = 1'b0;
      rd_p    = 1'b0;
      ref_p   = 1'b0;
      if (!RESET_N) begin
         active  = 1'b0;
         pull    = 1'b0;
         reading = 1'b0;
         go_read = 1'b0;
         reads   = 0;
      end else if (scl && scl_q && sda_q && !sda) begin
         start_p  = 1'b1;             // start or repeated start
         active   = 1'b1;
         bit_cnt  = 4'd0;
         byte_cnt = 2'd0;
         reading  = 1'b0;
         go_read  = 1'b0;
         pull     = 1'b0;
      end else if (scl && scl_q && !sda_q && sda) begin
         stop_p = 1'b1;
         active = 1'b0;
         pull   = 1'b0;
      end else if (active && scl && !scl_q) begin
         if (bit_cnt < 4'd8)
            shift = {shift[6:0], sda};
         bit_cnt = bit_cnt + 4'd1;
      end else if (active && !scl && scl_q) begin
         if (bit_cnt == 4'd8 && reading) begin
            pull = 1'b0;              // master answers with nack
         end else if (bit_cnt == 4'd8) begin
            pull = 1'b1;
            case (byte_cnt)
               2'd0: begin
                  dev     = shift;
                  go_read = shift[0];
                  if ((shift | 8'h01) != (`CAM_I2C_ADDR | 8'h01)) begin
                     pull   = 1'b0;   // someone else's address
                     active = 1'b0;
                  end else if (refuse) begin
                     pull   = 1'b0;
                     active = 1'b0;
                     ref_p  = 1'b1;
                  end
               end
               2'd1: ptr[15:8] = shift;
               2'd2: ptr[7:0]  = shift;
               default: begin
                  rep  = '{tag: dev, reg_addr: ptr, value: shift};
                  wr_p = 1'b1;
               end
            endcase
         end else if (bit_cnt == 4'd9) begin
            pull     = 1'b0;
            bit_cnt  = 4'd0;
            byte_cnt = byte_cnt + 2'd1;
            if (go_read) begin
               go_read = 1'b0;
               reading = 1'b1;
               rdata   = (reads == 0) ? 8'h00 : `CAM_ID_VALUE;   // first id read is wrong
               reads   = reads + 1;
               rd_p    = 1'b1;
               pull    = ~rdata[7];
               rdata   = {rdata[6:0], 1'b0};
            end
         end else if (reading && bit_cnt != 4'd0) begin
            pull  = ~rdata[7];
            rdata = {rdata[6:0], 1'b0};
         end
      end
      scl_q = scl;
      sda_q = sda;
   end

endmodule

`default_nettype wire

// File: verif/cam_config_properties.sv
`timescale 1ns/100ps
`default_nettype none

module cam_config_properties (
   input logic                   CLK_400K,
   input logic                   RESET_N,
   input logic                   cmd_valid,
   input i2c_pkg::i2c_cmd_t      cmd,
   input i2c_pkg::i2c_rsp_t      rsp,
   input logic                   scl,
   input logic                   sda_drive_low,
   input i2c_pkg::i2c_state_e    state
);
   import i2c_pkg::*;

   cmd_hold: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      cmd_valid && !rsp.done |=> $stable(cmd))
      else $error("command changed before done");

   // the requester lets go of valid right after done
   done_pulse: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      rsp.done |=> !rsp.done && !cmd_valid)
      else $error("done held longer than one cycle or valid not dropped");

   // data moves only while scl is low except in start and stop
   sda_steady: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      scl && $past(scl) && !(state inside {I2C_START, I2C_STOP})
         && !($past(state) inside {I2C_START, I2C_STOP}) |-> $stable(sda_drive_low))
      else $error("sda changed while scl high");

endmodule

bind i2c_master cam_config_properties u_props (
   .CLK_400K      (CLK_400K),
   .RESET_N       (RESET_N),
   .cmd_valid     (cmd_valid),
   .cmd           (cmd),
   .rsp           (rsp),
   .scl           (scl),
   .sda_drive_low (sda_drive_low),
   .state         (state)
);

`default_nettype wire

// File: verif/cam_config_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cam_config.svh"

module cam_config_tb;
   import cam_pkg::*;

   logic        CLK_400K;
   logic        RESET_N;
   cam_live_t   live;
   logic        refuse;
   logic        scl;
   logic        sda_drive_low;
   logic        sda_pull;
   wire         sda;
   logic [7:0]  sensor_id;
   logic        config_done;
   logic        start_seen;
   logic        stop_seen;
   logic        wr_valid;
   logic        rd_valid;
   logic        refused;
   cam_entry_t  wr_rep;
   cam_entry_t  exp_e;
   logic [15:0] rd_reg;
   logic [31:0] lfsr = 32'h8cd1;
   logic        gap_due = 1'b0;       // a delay entry sits before the next write
   int          cycle = 0;
   int          id_reads = 0;
   int          writes = 0;
   int          gap_checks = 0;
   int          exp_idx = 0;
   int          last_start = 0;
   int          last_stop = 0;

   assign sda = ~(sda_drive_low | sda_pull);   // pulled up unless someone drives low

   cam_config_top u_dut (
      .CLK_400K      (CLK_400K),
      .RESET_N       (RESET_N),
      .live          (live),
      .sda_in        (sda),
      .scl           (scl),
      .sda_drive_low (sda_drive_low),
      .sensor_id     (sensor_id),
      .config_done   (config_done)
   );

   i2c_sensor_model u_sensor (
      .CLK_400K   (CLK_400K),
      .RESET_N    (RESET_N),
      .scl        (scl),
      .sda        (sda),
      .refuse     (refuse),
      .sda_pull   (sda_pull),
      .start_seen (start_seen),
      .stop_seen  (stop_seen),
      .wr_valid   (wr_valid),
      .wr_rep     (wr_rep),
      .rd_valid   (rd_valid),
      .rd_reg     (rd_reg),
      .refused    (refused)
   );

   initial begin
      CLK_400K = 1'b0;
      forever #4 CLK_400K = ~CLK_400K;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = 32'h0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   function automatic cam_entry_t table_write(input logic [15:0] a, input logic [7:0] v);
      return '{tag: `CAM_I2C_ADDR, reg_addr: a, value: v};
   endfunction

   // reference register table with delay entries tagged
   function automatic cam_entry_t expected_entry(input int idx, input cam_live_t lv);
      case (idx)
         0:  return table_write(16'h0103, 8'h01);
         2:  return table_write(16'h0100, 8'h00);
         3:  return table_write(16'h0302, 8'h18);
         4:  return table_write(16'h0303, 8'h00);
         5:  return table_write(16'h0304, 8'h03);
         6:  return table_write(16'h3018, 8'h72);
         7:  return table_write(16'h3031, 8'h0a);
         8:  return table_write(16'h380c, 8'h12);
         9:  return table_write(16'h380d, 8'h00);
         10: return table_write(16'h5000, 8'h16);
         12: return table_write(16'h0100, 8'h01);
         13: return table_write(16'h3500, lv.exposure[23:16]);
         14: return table_write(16'h3501, lv.exposure[15:8]);
         15: return table_write(16'h3502, lv.exposure[7:0]);
         16: return table_write(16'h5e00, lv.test_pattern);
         17: return table_write(16'h3808, lv.width[15:8]);
         18: return table_write(16'h3809, lv.width[7:0]);
         19: return table_write(16'h380a, lv.height[15:8]);
         20: return table_write(16'h380b, lv.height[7:0]);
         default: return '{tag: `CAM_DELAY_TAG, reg_addr: 16'h0000, value: 8'd10};
      endcase
   endfunction

   function automatic int next_index(input int idx);
      return (idx == int'(`CAM_TABLE_LEN) - 1) ? int'(`CAM_LIVE_START) : idx + 1;
   endfunction

   task automatic wait_bus(input int limit, output logic is_rd, output cam_entry_t e);
      int n;
      n = 0;
      do begin
         @(posedge CLK_400K);
         n++;
         if (n > limit)
            abort_run("no bus transaction finished before the timeout");
      end while (!wr_valid && !rd_valid);
      is_rd = rd_valid;
      e     = wr_rep;
   endtask

   task automatic verify_reset_outputs();
      check_value("scl", 32'(scl), 32'd1);
      check_value("sda_drive_low", 32'(sda_drive_low), 32'd0);
      check_value("config_done", 32'(config_done), 32'd0);
      check_value("sensor_id", 32'(sensor_id), 32'd0);
   endtask

   // compare every captured write with the reference table
   always @(posedge CLK_400K) begin
      cycle++;
      if (start_seen)
         last_start = cycle;
      if (stop_seen)
         last_stop = cycle;
      if (rd_valid) begin
         check_value("rd_reg", 32'(rd_reg), 32'(`CAM_ID_REG));
         id_reads++;
         exp_idx = 0;                  // walk restarts after every id read
         gap_due = 1'b0;
      end
      if (wr_valid) begin
         exp_e = expected_entry(exp_idx, live);
         while (exp_e.tag == `CAM_DELAY_TAG) begin
            exp_idx = next_index(exp_idx);
            exp_e   = expected_entry(exp_idx, live);
            gap_due = 1'b1;
         end
         check_value("wr_dev", 32'(wr_rep.tag), 32'(exp_e.tag));
         check_value("wr_reg", 32'(wr_rep.reg_addr), 32'(exp_e.reg_addr));
         check_value("wr_data", 32'(wr_rep.value), 32'(exp_e.value));
         if (gap_due) begin
            if (last_start - last_stop < 10 * int'(`CAM_DELAY_UNIT))
               abort_run("bus idle time for a delay entry was too short");
            gap_checks++;
         end
         gap_due = 1'b0;
         writes++;
         exp_idx = next_index(exp_idx);
      end
   end

   initial begin
      cam_entry_t  e;
      cam_live_t   nl;
      logic        is_rd;
      logic [31:0] r;
      logic [4:0]  got;
      int          n;
      int          passes;
      RESET_N = 1'b0;
      refuse  = 1'b0;
      live    = '{exposure: 24'h012345, test_pattern: 8'h00,
                  width: 16'h0780, height: 16'h0438};
      repeat (2) @(posedge CLK_400K);
      #1;
      verify_reset_outputs();
      repeat (14) @(posedge CLK_400K);
      #1;
      RESET_N = 1'b1;
      verify_reset_outputs();

      is_rd = 1'b1;
      while (is_rd)
         wait_bus(4000, is_rd, e);
      check_value("id_reads", 32'(id_reads), 32'd2);
      check_value("sensor_id", 32'(sensor_id), 32'(`CAM_ID_VALUE));

      n = 0;
      while (!config_done) begin
         @(posedge CLK_400K);
         n++;
         if (n > 20000)
            abort_run("config_done did not rise after the table walk");
      end
      #1;
      check_value("table_writes", 32'(writes), 32'd19);
      check_value("gap_checks", 32'(gap_checks), 32'd2);

      wait_bus(4000, is_rd, e);        // data of this write already latched
      #1;
      nl = live;
      draw_bits(24, r);
      nl.exposure = r[23:0];
      draw_bits(16, r);
      nl.width = r[15:0];
      live = nl;
      passes = 0;
      got = 5'b00000;
      while (got != 5'b11111) begin
         wait_bus(4000, is_rd, e);
         if (is_rd)
            abort_run("unexpected id read during the live refresh");
         case (e.reg_addr)
            16'h3500: begin
               passes++;
               if (passes > 2)
                  abort_run("new live values not written within two passes");
               check_value("exposure_hi", 32'(e.value), 32'(nl.exposure[23:16]));
               got[0] = 1'b1;
            end
            16'h3501: got[1] = 1'b1;
            16'h3502: got[2] = 1'b1;
            16'h3808: got[3] = 1'b1;
            16'h3809: begin
               check_value("width_lo", 32'(e.value), 32'(nl.width[7:0]));
               got[4] = 1'b1;
            end
            default: ;
         endcase
      end

      #1;
      refuse = 1'b1;
      n = 0;
      while (!refused) begin
         @(posedge CLK_400K);
         n++;
         if (n > 4000)
            abort_run("sensor never saw an address to refuse");
      end
      #1;
      refuse = 1'b0;
      wait_bus(4000, is_rd, e);
      check_value("id_read_after_nack", 32'(is_rd), 32'd1);
      check_value("rd_reg", 32'(rd_reg), 32'(`CAM_ID_REG));
      wait_bus(4000, is_rd, e);
      check_value("restart_is_write", 32'(is_rd), 32'd0);
      check_value("restart_reg", 32'(e.reg_addr), 32'h0103);
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
src/i2c_pkg.sv
src/cam_pkg.sv
src/i2c_master.sv
src/cam_reg_table.sv
src/cam_init_seq.sv
src/cam_config_top.sv
verif/i2c_sensor_model.sv
verif/cam_config_properties.sv
verif/cam_config_tb.sv

// File: run.sh
#!/bin/bash
# build and run the camera config testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module cam_config_tb \
   -o cam_config_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/cam_config_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Regression passed" sim.log; then
   exit 0
fi
exit 1
